// ==== Bender.yml ====
package:
  name: cpu

sources:
  - hw/cpu_pkg.sv
  - hw/cpu_if.sv
  - hw/px.sv
  - hw/pm.sv
  - hw/pd.sv
  - hw/pr.sv
  - hw/pa.sv
  - hw/cpu.sv
  - target: test
    files:
      - tests/cpu_chk.sv
      - tests/cpu_tb.sv

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input wire logic __clk,
	input wire logic rst,

	// operator
	input wire logic start_,
	input wire logic stop_,
	output logic run,
	output logic hlt_n_,
	output logic awaria_,
	output cpu_pkg::word_t w,

	// system bus
	output logic dr_,
	output logic dw_,
	input wire logic rok_,
	output cpu_pkg::word_t dad_,
	output cpu_pkg::word_t ddt_,
	input wire cpu_pkg::word_t rdt_
);

	dec_if dec_i ();
	cyc_if cyc_i ();

	logic alarm;
	logic start_run;
	logic w_r;
	logic z;
	cpu_pkg::word_t ra_val;
	cpu_pkg::word_t rb_val;
	cpu_pkg::word_t wr_val;

	// ---------------------------------------
	// timing and control
	// ---------------------------------------

	px px_i (
		.__clk(__clk),
		.rst(rst),
		.rok_(rok_),
		.start_run(start_run),
		.dr_(dr_),
		.dw_(dw_),
		.alarm(alarm),
		.cyc(cyc_i)
	);

	pm pm_i (
		.__clk(__clk),
		.rst(rst),
		.start_(start_),
		.stop_(stop_),
		.alarm(alarm),
		.run(run),
		.hlt_n_(hlt_n_),
		.awaria_(awaria_),
		.start_run(start_run),
		.cyc(cyc_i),
		.dec(dec_i)
	);

	pd pd_i (
		.__clk(__clk),
		.rst(rst),
		.w(w),
		.cyc(cyc_i),
		.dec(dec_i)
	);

	// ---------------------------------------
	// data path
	// ---------------------------------------

	pr pr_i (
		.__clk(__clk),
		.rst(rst),
		.w_r(w_r),
		.wr_val(wr_val),
		.ra_val(ra_val),
		.rb_val(rb_val),
		.z(z),
		.dec(dec_i),
		.cyc(cyc_i)
	);

	pa pa_i (
		.__clk(__clk),
		.rst(rst),
		.rdt_(rdt_),
		.ra_val(ra_val),
		.rb_val(rb_val),
		.z(z),
		.dad_(dad_),
		.ddt_(ddt_),
		.w(w),
		.wr_val(wr_val),
		.w_r(w_r),
		.dec(dec_i),
		.cyc(cyc_i)
	);

endmodule

`default_nettype wire

// ==== hw/cpu_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded instruction fields
interface dec_if;

	cpu_pkg::op_e op;
	logic [0:2] ra;
	logic [0:2] rb;
	cpu_pkg::word_t t; // already sign-extended
	logic two_word;

	modport drv (
		output op, ra, rb, t, two_word
	);

	modport rcv (
		input op, ra, rb, t, two_word
	);

endinterface

// processor cycle timing
interface cyc_if;

	cpu_pkg::state_e state;
	logic strob1; // last cycle of a state
	logic bus_ok; // memory reply taken
	cpu_pkg::state_e nxt_state;

	// sequencer side
	modport drv (
		output state, strob1, bus_ok,
		input nxt_state
	);

	// control side, picks the next state
	modport ctl (
		input state, strob1, bus_ok,
		output nxt_state
	);

	modport rcv (
		input state, strob1, bus_ok
	);

endinterface

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ---------------------------------------
	// data word, bit 0 is the msb
	// ---------------------------------------

	typedef logic [0:15] word_t;

	// instruction opcodes, bits 0..5 of the first word
	typedef enum logic [0:5] {
		OP_LD  = 6'o20, // load from address in 2nd word
		OP_RW  = 6'o24, // store register a
		OP_AW  = 6'o40,
		OP_SW  = 6'o42,
		OP_OR  = 6'o44,
		OP_NR  = 6'o46,
		OP_LWT = 6'o65, // short constant
		OP_UJ  = 6'o70,
		OP_JZ  = 6'o71,
		OP_HLT = 6'o73
	} op_e;

	// processor states
	typedef enum logic [2:0] {
		ST_STOP = 3'd0, // idle
		ST_P1   = 3'd1, // instruction fetch
		ST_K2   = 3'd2, // argument fetch
		ST_WX   = 3'd3, // execute
		ST_WR   = 3'd4, // memory read
		ST_WW   = 3'd5  // memory write
	} state_e;

	// ---------------------------------------
	// timings, in clock cycles
	// ---------------------------------------

	localparam logic [2:0] STROB_TICKS = 3'd3;      // length of a non-bus state
	localparam logic [7:0] ALARM_DLY_TICKS = 8'd32; // max wait for rok_

	localparam int NREG = 8; // general registers r0..r7

endpackage

`default_nettype wire

// ==== hw/pa.sv ====
`timescale 1ns/1ps
`default_nettype none

module pa (
	input wire logic __clk,
	input wire logic rst,
	input wire cpu_pkg::word_t rdt_,
	input wire cpu_pkg::word_t ra_val,
	input wire cpu_pkg::word_t rb_val,
	input wire logic z,
	output cpu_pkg::word_t dad_,
	output cpu_pkg::word_t ddt_,
	output cpu_pkg::word_t w,
	output cpu_pkg::word_t wr_val,
	output logic w_r,
	dec_if.rcv dec,
	cyc_if.rcv cyc
);

	cpu_pkg::word_t ic_q;
	cpu_pkg::word_t ar_q;
	cpu_pkg::word_t at_q; // argument latch
	cpu_pkg::word_t rdt;
	cpu_pkg::word_t alu;
	logic fetch;
	logic jump;

	assign rdt = ~rdt_;
	assign fetch = cyc.bus_ok && (cyc.state inside {cpu_pkg::ST_P1, cpu_pkg::ST_K2});
	assign jump = cyc.strob1 && (cyc.state == cpu_pkg::ST_WX)
		&& ((dec.op == cpu_pkg::OP_UJ) || ((dec.op == cpu_pkg::OP_JZ) && z));

	// ---------------------------------------
	// IC and AR
	// ---------------------------------------

	always_ff @(posedge __clk) begin
		if (rst) begin
			ic_q <= '0;
		end else if (fetch) begin
			ic_q <= ic_q + 16'd1;
		end else if (jump) begin
			ic_q <= ar_q;
		end
	end

	always_ff @(posedge __clk) begin
		if (cyc.bus_ok && (cyc.state == cpu_pkg::ST_K2)) begin
			ar_q <= rdt; // address from 2nd word
		end
	end

	// ---------------------------------------
	// arithmetic
	// ---------------------------------------

	always_ff @(posedge __clk) begin
		if (cyc.state == cpu_pkg::ST_WX) begin
			at_q <= (dec.op == cpu_pkg::OP_LWT) ? dec.t : rb_val;
		end
	end

	always_comb begin
		case (dec.op)
			cpu_pkg::OP_AW: alu = ra_val + at_q; // wraps
			cpu_pkg::OP_SW: alu = ra_val - at_q;
			cpu_pkg::OP_NR: alu = ra_val & at_q;
			cpu_pkg::OP_OR: alu = ra_val | at_q;
			default: alu = at_q; // LWT
		endcase
	end

	assign w_r = ((cyc.state == cpu_pkg::ST_WX) && (dec.op inside {cpu_pkg::OP_LWT,
		cpu_pkg::OP_AW, cpu_pkg::OP_SW, cpu_pkg::OP_NR, cpu_pkg::OP_OR}))
		|| ((cyc.state == cpu_pkg::ST_WR) && (dec.op == cpu_pkg::OP_LD));
	assign wr_val = (cyc.state == cpu_pkg::ST_WR) ? rdt : alu;

	// ---------------------------------------
	// bus and W
	// ---------------------------------------

	// IC for fetches, AR for operand transfers
	assign dad_ = (cyc.state inside {cpu_pkg::ST_WR, cpu_pkg::ST_WW}) ? ~ar_q : ~ic_q;
	assign ddt_ = (cyc.state == cpu_pkg::ST_WW) ? ~ra_val : '1;

	always_comb begin
		case (cyc.state)
			cpu_pkg::ST_P1, cpu_pkg::ST_K2, cpu_pkg::ST_WR: w = rdt;
			cpu_pkg::ST_WW: w = ra_val;
			cpu_pkg::ST_WX: w = alu;
			default: w = ic_q; // stopped
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/pd.sv ====
`timescale 1ns/1ps
`default_nettype none

module pd (
	input wire logic __clk,
	input wire logic rst,
	input wire cpu_pkg::word_t w,
	cyc_if.rcv cyc,
	dec_if.drv dec
);

	cpu_pkg::word_t ir_q;
	cpu_pkg::word_t iw; // word being decoded
	logic load;
	cpu_pkg::op_e op;

	assign load = (cyc.state == cpu_pkg::ST_P1) && cyc.bus_ok;

	always_ff @(posedge __clk) begin
		if (rst) begin
			ir_q <= '0;
		end else if (load) begin
			ir_q <= w;
		end
	end

	// decode straight from W while IR loads, next state depends on it
	assign iw = load ? w : ir_q;

	// ---------------------------------------
	// opcode
	// ---------------------------------------

	always_comb begin
		case (iw[0:5])
			cpu_pkg::OP_LWT, cpu_pkg::OP_AW, cpu_pkg::OP_SW, cpu_pkg::OP_NR,
			cpu_pkg::OP_OR, cpu_pkg::OP_LD, cpu_pkg::OP_RW, cpu_pkg::OP_UJ,
			cpu_pkg::OP_JZ, cpu_pkg::OP_HLT:
				op = cpu_pkg::op_e'(iw[0:5]);
			default: op = cpu_pkg::OP_HLT; // illegal stops like HLT
		endcase
	end

	assign dec.op = op;
	assign dec.ra = iw[7:9];
	assign dec.rb = iw[13:15];
	assign dec.t = {{10{iw[10]}}, iw[10:15]}; // bit 10 is the sign
	assign dec.two_word = op inside {cpu_pkg::OP_LD, cpu_pkg::OP_RW,
		cpu_pkg::OP_UJ, cpu_pkg::OP_JZ};

endmodule

`default_nettype wire

// ==== hw/pm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pm (
	input wire logic __clk,
	input wire logic rst,
	input wire logic start_,
	input wire logic stop_,
	input wire logic alarm,
	output logic run,
	output logic hlt_n_,
	output logic awaria_,
	output logic start_run,
	cyc_if.ctl cyc,
	dec_if.rcv dec
);

	logic run_q;
	logic stop_q; // stop pending until end of instruction
	logic hlt_q;
	logic alm_q;
	logic end_instr;
	logic halt_now;
	logic run_clr;
	logic go;
	cpu_pkg::state_e nxt;

	assign end_instr = cyc.strob1 && (cyc.state inside {cpu_pkg::ST_WX,
		cpu_pkg::ST_WR, cpu_pkg::ST_WW});
	assign halt_now = end_instr && (cyc.state == cpu_pkg::ST_WX)
		&& (dec.op == cpu_pkg::OP_HLT);
	assign run_clr = end_instr & (stop_q | ~stop_ | halt_now);
	assign go = ~start_ & ~run_q & (cyc.state == cpu_pkg::ST_STOP);

	always_ff @(posedge __clk) begin
		if (rst) begin
			run_q <= 1'b0;
			stop_q <= 1'b0;
			hlt_q <= 1'b0;
			alm_q <= 1'b0;
		end else begin
			if (alarm || run_clr) run_q <= 1'b0;
			else if (go) run_q <= 1'b1;
			if (alarm || run_clr || go) stop_q <= 1'b0;
			else if (!stop_ && run_q) stop_q <= 1'b1;
			if (halt_now) hlt_q <= 1'b1;
			else if (go) hlt_q <= 1'b0;
			if (alarm) alm_q <= 1'b1;
			else if (go) alm_q <= 1'b0;
		end
	end

	// ---------------------------------------
	// next state
	// ---------------------------------------

	always_comb begin
		case (cyc.state)
			cpu_pkg::ST_P1: nxt = dec.two_word ? cpu_pkg::ST_K2 : cpu_pkg::ST_WX;
			cpu_pkg::ST_K2: begin
				if (dec.op == cpu_pkg::OP_LD) nxt = cpu_pkg::ST_WR;
				else if (dec.op == cpu_pkg::OP_RW) nxt = cpu_pkg::ST_WW;
				else nxt = cpu_pkg::ST_WX; // jumps
			end
			cpu_pkg::ST_WX, cpu_pkg::ST_WR, cpu_pkg::ST_WW:
				nxt = (run_q && !run_clr) ? cpu_pkg::ST_P1 : cpu_pkg::ST_STOP;
			default: nxt = cpu_pkg::ST_STOP;
		endcase
	end

	assign cyc.nxt_state = nxt;

	assign start_run = run_q & (cyc.state == cpu_pkg::ST_STOP);
	assign run = run_q;
	assign hlt_n_ = ~hlt_q;
	assign awaria_ = ~alm_q;

endmodule

`default_nettype wire

// ==== hw/pr.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr (
	input wire logic __clk,
	input wire logic rst,
	input wire logic w_r,
	input wire cpu_pkg::word_t wr_val,
	output cpu_pkg::word_t ra_val,
	output cpu_pkg::word_t rb_val,
	output logic z,
	dec_if.rcv dec,
	cyc_if.rcv cyc
);

	cpu_pkg::word_t regs [0:cpu_pkg::NREG-1];
	logic z_q;
	logic wr_en;

	// write at the end of WX or on the read reply
	assign wr_en = w_r & cyc.strob1;

	always_ff @(posedge __clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::NREG; i++) begin
				regs[i] <= '0;
			end
			z_q <= 1'b0;
		end else if (wr_en) begin
			regs[dec.ra] <= wr_val;
			z_q <= (wr_val == '0); // every register write sets Z
		end
	end

	// ---------------------------------------
	// read ports
	// ---------------------------------------

	assign ra_val = regs[dec.ra];
	assign rb_val = regs[dec.rb];
	assign z = z_q;

endmodule

`default_nettype wire

// ==== hw/px.sv ====
`timescale 1ns/1ps
`default_nettype none

module px (
	input wire logic __clk,
	input wire logic rst,
	input wire logic rok_,
	input wire logic start_run,
	output logic dr_,
	output logic dw_,
	output logic alarm,
	cyc_if.drv cyc
);

	cpu_pkg::state_e state_q;
	logic [2:0] tick_q;
	logic [7:0] dly_q;
	logic req_q;
	logic bus_st;
	logic tick_end;
	logic bus_ok;
	logic strob1;

	// ---------------------------------------
	// state timing
	// ---------------------------------------

	assign bus_st = state_q inside {cpu_pkg::ST_P1, cpu_pkg::ST_K2,
		cpu_pkg::ST_WR, cpu_pkg::ST_WW};

	// only WX runs on the tick counter
	assign tick_end = (state_q == cpu_pkg::ST_WX)
		&& (tick_q == cpu_pkg::STROB_TICKS - 3'd1);

	assign bus_ok = req_q & ~rok_;
	assign strob1 = bus_ok | tick_end;

	always_ff @(posedge __clk) begin
		if (rst || tick_end || (state_q != cpu_pkg::ST_WX)) begin
			tick_q <= 3'd0;
		end else begin
			tick_q <= tick_q + 3'd1;
		end
	end

	always_ff @(posedge __clk) begin
		if (rst) begin
			state_q <= cpu_pkg::ST_STOP;
		end else if (alarm) begin
			state_q <= cpu_pkg::ST_STOP; // instruction abandoned
		end else if (strob1) begin
			state_q <= cyc.nxt_state;
		end else if ((state_q == cpu_pkg::ST_STOP) && start_run) begin
			state_q <= cpu_pkg::ST_P1;
		end
	end

	// ---------------------------------------
	// bus request and reply
	// ---------------------------------------

	// request waits for rok_ released by the previous transfer
	always_ff @(posedge __clk) begin
		if (rst) begin
			req_q <= 1'b0;
		end else if (bus_ok || alarm) begin
			req_q <= 1'b0;
		end else if (bus_st && rok_) begin
			req_q <= 1'b1;
		end
	end

	assign dr_ = ~(req_q & (state_q != cpu_pkg::ST_WW));
	assign dw_ = ~(req_q & (state_q == cpu_pkg::ST_WW));

	// no reply in time
	always_ff @(posedge __clk) begin
		if (rst || !req_q) begin
			dly_q <= 8'd0;
		end else begin
			dly_q <= dly_q + 8'd1;
		end
	end

	assign alarm = req_q & rok_ & (dly_q == cpu_pkg::ALARM_DLY_TICKS - 8'd1);

	assign cyc.state = state_q;
	assign cyc.strob1 = strob1;
	assign cyc.bus_ok = bus_ok;

endmodule

`default_nettype wire

// ==== tests/cpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
	input wire logic __clk,
	input wire logic rst,
	input wire logic dr_,
	input wire logic dw_,
	input wire cpu_pkg::word_t dad_,
	input wire logic awaria_,
	input wire logic run,
	input wire logic hlt_n_
);

	// ----------------------------------------
	// bus rules
	// ----------------------------------------

	read_write_apart: assert property (@(posedge __clk) disable iff (rst)
		!(!dr_ && !dw_)) else $error("dr_ and dw_ low together");

	addr_stable: assert property (@(posedge __clk) disable iff (rst)
		(!dr_ || !dw_) |=> ((dr_ && dw_) || $stable(dad_)))
		else $error("dad_ moved during a request");

	alarm_drops_req: assert property (@(posedge __clk) disable iff (rst)
		$fell(awaria_) |-> (dr_ && dw_)) else $error("request still low after alarm");

	halt_not_running: assert property (@(posedge __clk) disable iff (rst)
		!hlt_n_ |-> !run) else $error("run high while halted");

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	logic __clk = 1'b0;
	logic rst = 1'b1;
	logic start_ = 1'b1;
	logic stop_ = 1'b1;
	logic rok_ = 1'b1;
	cpu_pkg::word_t rdt_ = '1;
	logic run;
	logic hlt_n_;
	logic awaria_;
	logic dr_;
	logic dw_;
	cpu_pkg::word_t dad_;
	cpu_pkg::word_t ddt_;
	cpu_pkg::word_t w;

	logic [15:0] mem [0:4095];
	cpu_pkg::op_e tab_op [$]; // program table, one row per test
	logic [5:0] tab_x [$];
	logic [5:0] tab_y [$];
	logic [15:0] tab_adr [$];
	logic [15:0] wr_adr [$]; // writes seen on the bus
	logic [15:0] wr_dat [$];
	logic [15:0] exp_adr [$];
	logic [15:0] exp_dat [$];
	logic [15:0] rd_word = '0; // last word put on the bus by a read
	logic table_ready = 1'b0;
	logic pending = 1'b0;
	int wait_cnt;
	int err_cnt = 0;
	int limit;
	integer seed = 18;

	always #5 __clk = ~__clk;

	cpu dut_i (
		.__clk(__clk),
		.rst(rst),
		.start_(start_),
		.stop_(stop_),
		.run(run),
		.hlt_n_(hlt_n_),
		.awaria_(awaria_),
		.w(w),
		.dr_(dr_),
		.dw_(dw_),
		.rok_(rok_),
		.dad_(dad_),
		.ddt_(ddt_),
		.rdt_(rdt_)
	);

	bind cpu cpu_chk chk_i (
		.__clk(__clk),
		.rst(rst),
		.dr_(dr_),
		.dw_(dw_),
		.dad_(dad_),
		.awaria_(awaria_),
		.run(run),
		.hlt_n_(hlt_n_)
	);

	// ----------------------------------------
	// memory model
	// ----------------------------------------

	always @(posedge __clk) begin
		logic [15:0] ba;
		if (!rok_ && !dr_) begin // read reply, W carries the fetched word
			check_val("w during read reply", w, rd_word);
		end
		#1;
		ba = ~dad_;
		if (rst || !rok_) begin
			rok_ = 1'b1; // reply lasts one cycle
			rdt_ = '1;
			pending = 1'b0;
		end else if (!dr_ || !dw_) begin
			if (!pending) begin
				pending = 1'b1;
				wait_cnt = $unsigned($random(seed)) % 5;
			end
			if (ba < 16'hF000) begin // no memory up there
				if (wait_cnt == 0) begin
					if (!dw_) begin
						mem[ba[11:0]] = ~ddt_;
						wr_adr.push_back(ba);
						wr_dat.push_back(~ddt_);
					end else begin
						rd_word = mem[ba[11:0]];
						rdt_ = ~rd_word;
					end
					rok_ = 1'b0;
				end else begin
					wait_cnt--;
				end
			end
		end else begin
			pending = 1'b0; // request dropped, e.g. after alarm
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR @%0t: %s, got %h expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] sext6(input logic [5:0] v);
		return {{10{v[5]}}, v};
	endfunction

	// background pattern, every address bit counts
	function automatic logic [15:0] fill(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3C5A;
	endfunction

	function automatic logic [15:0] enc(input logic [5:0] op, input logic [2:0] ra,
		input logic [5:0] lo);
		return {op, 1'b0, ra, lo};
	endfunction

	function automatic logic [15:0] op_result(input cpu_pkg::op_e op, input logic [15:0] a,
		input logic [15:0] b);
		case (op)
			cpu_pkg::OP_AW: return a + b;
			cpu_pkg::OP_SW: return a - b;
			cpu_pkg::OP_NR: return a & b;
			default: return a | b;
		endcase
	endfunction

	task automatic add_row(input cpu_pkg::op_e op, input logic [5:0] x, input logic [5:0] y,
		input logic [15:0] adr);
		tab_op.push_back(op);
		tab_x.push_back(x);
		tab_y.push_back(y);
		tab_adr.push_back(adr);
	endtask

	task automatic expect_write(input logic [15:0] a, input logic [15:0] d);
		exp_adr.push_back(a);
		exp_dat.push_back(d);
	endtask

	task automatic pulse_start;
		@(posedge __clk);
		#1 start_ = 1'b0;
		@(posedge __clk);
		#1 start_ = 1'b1;
	endtask

	// halted, alarmed or stopped
	task automatic wait_stopped;
		@(posedge __clk);
		#1;
		while (run && hlt_n_ && awaria_) begin
			@(posedge __clk);
			#1;
		end
	endtask

	// ----------------------------------------
	// one table row
	// ----------------------------------------

	task automatic run_row(input int i);
		cpu_pkg::op_e op;
		logic [15:0] sx;
		logic [15:0] sy;
		logic [15:0] mark;
		logic [15:0] skip;
		logic alarm_exp;
		logic halt_resume;
		op = tab_op[i];
		sx = sext6(tab_x[i]);
		sy = sext6(tab_y[i]);
		mark = 16'h0800 + i[15:0];
		skip = 16'h0900 + i[15:0]; // must only show up on fall-through
		alarm_exp = 1'b0;
		halt_resume = 1'b0;
		exp_adr.delete();
		exp_dat.delete();
		wr_adr.delete();
		wr_dat.delete();
		@(posedge __clk);
		#1 rst = 1'b1;
		for (int a = 0; a < 4096; a++) begin
			mem[a] = fill(a[15:0]);
		end
		mem[0] = enc(cpu_pkg::OP_LWT, 3'd1, tab_x[i]);
		mem[1] = enc(cpu_pkg::OP_LWT, 3'd2, tab_y[i]);
		case (op)
			cpu_pkg::OP_LD: begin
				mem[2] = enc(cpu_pkg::OP_LD, 3'd1, 6'd0);
				mem[3] = tab_adr[i];
				mem[4] = enc(cpu_pkg::OP_RW, 3'd1, 6'd0);
				mem[5] = mark;
				mem[6] = enc(6'o77, 3'd0, 6'd0); // unknown opcode, stops like HLT
				alarm_exp = (tab_adr[i] >= 16'hF000);
				if (!alarm_exp) expect_write(mark, fill(tab_adr[i]));
			end
			cpu_pkg::OP_UJ: begin
				mem[2] = enc(cpu_pkg::OP_UJ, 3'd0, 6'd0);
				mem[3] = 16'd6;
				mem[4] = enc(cpu_pkg::OP_RW, 3'd1, 6'd0);
				mem[5] = skip;
				mem[6] = enc(cpu_pkg::OP_RW, 3'd2, 6'd0);
				mem[7] = mark;
				mem[8] = enc(cpu_pkg::OP_HLT, 3'd0, 6'd0);
				expect_write(mark, sy);
			end
			cpu_pkg::OP_JZ: begin
				mem[2] = enc(cpu_pkg::OP_SW, 3'd1, 6'd2);
				mem[3] = enc(cpu_pkg::OP_JZ, 3'd0, 6'd0);
				mem[4] = 16'd7;
				mem[5] = enc(cpu_pkg::OP_RW, 3'd1, 6'd0);
				mem[6] = skip;
				mem[7] = enc(cpu_pkg::OP_RW, 3'd2, 6'd0);
				mem[8] = mark;
				mem[9] = enc(cpu_pkg::OP_HLT, 3'd0, 6'd0);
				if (sx != sy) expect_write(skip, sx - sy);
				expect_write(mark, sy);
			end
			cpu_pkg::OP_HLT: begin
				mem[2] = enc(cpu_pkg::OP_HLT, 3'd0, 6'd0);
				mem[3] = enc(cpu_pkg::OP_RW, 3'd1, 6'd0);
				mem[4] = mark;
				mem[5] = enc(cpu_pkg::OP_HLT, 3'd0, 6'd0); // not reached, stop_ ends the run
				halt_resume = 1'b1;
				expect_write(mark, sx);
			end
			default: begin // register to register
				mem[2] = enc(op, 3'd1, 6'd2);
				mem[3] = enc(cpu_pkg::OP_RW, 3'd1, 6'd0);
				mem[4] = mark;
				mem[5] = enc(cpu_pkg::OP_HLT, 3'd0, 6'd0);
				expect_write(mark, op_result(op, sx, sy));
			end
		endcase
		repeat (16) @(posedge __clk);
		#1 rst = 1'b0;
		@(posedge __clk);
		#1;
		check_val($sformatf("row %0d run after reset", i), run, 1'b0);
		check_val($sformatf("row %0d dr_ after reset", i), dr_, 1'b1);
		check_val($sformatf("row %0d dw_ after reset", i), dw_, 1'b1);
		check_val($sformatf("row %0d hlt_n_ after reset", i), hlt_n_, 1'b1);
		check_val($sformatf("row %0d awaria_ after reset", i), awaria_, 1'b1);
		pulse_start();
		wait_stopped();
		if (halt_resume) begin
			check_val($sformatf("row %0d writes before resume", i), wr_adr.size(), 0);
			check_val($sformatf("row %0d run at halt", i), run, 1'b0);
			check_val($sformatf("row %0d hlt_n_ at halt", i), hlt_n_, 1'b0);
			pulse_start();
			stop_ = 1'b0; // stop at the end of the resumed RW
			@(posedge __clk);
			#1 stop_ = 1'b1;
			wait_stopped();
		end
		repeat (8) @(posedge __clk); // a late write would show here
		#1;
		check_val($sformatf("row %0d run at end", i), run, 1'b0);
		check_val($sformatf("row %0d awaria_ at end", i), awaria_, !alarm_exp);
		check_val($sformatf("row %0d hlt_n_ at end", i), hlt_n_, alarm_exp | halt_resume);
		check_val($sformatf("row %0d write count", i), wr_adr.size(), exp_adr.size());
		for (int k = 0; k < exp_adr.size(); k++) begin
			check_val($sformatf("row %0d write %0d address", i, k), wr_adr[k], exp_adr[k]);
			check_val($sformatf("row %0d write %0d data", i, k), wr_dat[k], exp_dat[k]);
		end
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------

	initial begin
		add_row(cpu_pkg::OP_AW, 6'd17, 6'd25, 16'h0000);
		add_row(cpu_pkg::OP_AW, -6'sd32, -6'sd32, 16'h0000); // wraps
		add_row(cpu_pkg::OP_SW, 6'd5, 6'd20, 16'h0000);
		add_row(cpu_pkg::OP_NR, -6'sd11, 6'd14, 16'h0000);
		add_row(cpu_pkg::OP_OR, 6'd9, -6'sd16, 16'h0000);
		add_row(cpu_pkg::OP_LD, 6'd0, 6'd0, 16'h0123);
		add_row(cpu_pkg::OP_UJ, 6'd3, 6'd7, 16'h0000);
		add_row(cpu_pkg::OP_JZ, 6'd12, 6'd12, 16'h0000); // zero, jumps
		add_row(cpu_pkg::OP_JZ, 6'd12, -6'sd4, 16'h0000);
		add_row(cpu_pkg::OP_HLT, 6'd21, 6'd0, 16'h0000);
		add_row(cpu_pkg::OP_LD, 6'd0, 6'd0, 16'hF000); // no reply, alarm
		table_ready = 1'b1;
		for (int i = 0; i < tab_op.size(); i++) begin
			run_row(i);
		end
		if (err_cnt == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1);
		end
	end

	initial begin
		wait (table_ready);
		limit = tab_op.size() * 200 + 1000;
		repeat (limit) @(posedge __clk);
		$display("timeout: the core did not finish all rows within %0d cycles", limit);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/cpu_pkg.sv
hw/cpu_if.sv
hw/px.sv
hw/pm.sv
hw/pd.sv
hw/pr.sv
hw/pa.sv
hw/cpu.sv
tests/cpu_chk.sv
tests/cpu_tb.sv
